/* bender.yml */
package:
  name: audio_backend

sources:
  # Design, package first
  - rtl/audio_pkg.sv
  - rtl/ce_divider.sv
  - rtl/fm_path.sv
  - rtl/psg_path.sv
  - rtl/audio_mixer.sv
  - rtl/audio_top.sv

  # Testbench, bound checks before the top module
  - target: simulation
    files:
      - dv/audio_asserts.sv
      - dv/audio_tb.sv

/* dv/audio_asserts.sv */
// Bound checks on clock-enable spacing and reset values of the audio back end
`timescale 1ns/1ps

module audio_asserts
	import audio_pkg::*;
(
	input logic        clk_sys,
	input logic        rst_n,
	input logic        fm_ce,
	input logic        psg_ce,
	input mix_sample_t audio_left,
	input mix_sample_t audio_right
);

	// FM pulse, then six quiet cycles, then the next pulse
	fm_ce_spacing : assert property (@(posedge clk_sys) disable iff (!rst_n)
		fm_ce |=> (!fm_ce)[*FM_CE_DIVIDE-1] ##1 fm_ce)
		else $error("fm_ce spacing differs from %0d cycles", FM_CE_DIVIDE);

	// Same shape for the slower PSG enable
	psg_ce_spacing : assert property (@(posedge clk_sys) disable iff (!rst_n)
		psg_ce |=> (!psg_ce)[*PSG_CE_DIVIDE-1] ##1 psg_ce)
		else $error("psg_ce spacing differs from %0d cycles", PSG_CE_DIVIDE);

	// Registers clear on the edge after reset is seen
	reset_quiet : assert property (@(posedge clk_sys)
		!rst_n |=> (!fm_ce && !psg_ce && audio_left == '0 && audio_right == '0))
		else $error("enables or audio outputs not zero during reset");

endmodule

bind audio_top audio_asserts asserts0 (
	.clk_sys     (clk_sys),
	.rst_n       (rst_n),
	.fm_ce       (fm_ce),
	.psg_ce      (psg_ce),
	.audio_left  (audio_left),
	.audio_right (audio_right)
);

/* dv/audio_tb.sv */
// Audio back end testbench, checks reset, enable pacing and trace-driven gain, mix and clamp
`timescale 1ns/1ps

module audio_tb
	import audio_pkg::*;
();

	localparam int RESET_CYCLES  = 5;
	// Covers three PSG periods after reset
	localparam int ENABLE_WINDOW = 45;
	localparam int WAIT_LIMIT    = 40;
	localparam int SETTLE_CYCLES = 2;
	// Expected enable periods in system clocks
	localparam int FM_PERIOD     = 7;
	localparam int PSG_PERIOD    = 15;
	localparam string TRACE_FILE = "dv/audio_trace.txt";

	logic        clk_sys;
	logic        rst_n;
	fm_sample_t  fm_left;
	fm_sample_t  fm_right;
	psg_sample_t psg_in;
	logic        fm_ce;
	logic        psg_ce;
	mix_sample_t audio_left;
	mix_sample_t audio_right;

	int mismatch_count;
	int timeout_count;
	// File and trace problems
	int other_count;
	int segment_count;

	audio_top dut0 (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.fm_left     (fm_left),
		.fm_right    (fm_right),
		.psg_in      (psg_in),
		.fm_ce       (fm_ce),
		.psg_ce      (psg_ce),
		.audio_left  (audio_left),
		.audio_right (audio_right)
	);

	// 10 ns system clock
	initial begin
		clk_sys = 1'b0;
		forever begin
			#5 clk_sys = ~clk_sys;
		end
	end

	task automatic compare_value(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
			mismatch_count++;
		end
	endtask

	// Enables and both audio channels at zero
	task automatic check_quiet(input string name);
		compare_value({name, " fm_ce"}, 0, int'(fm_ce));
		compare_value({name, " psg_ce"}, 0, int'(psg_ce));
		compare_value({name, " audio_left"}, 0, int'(audio_left));
		compare_value({name, " audio_right"}, 0, int'(audio_right));
	endtask

	// New levels 1 ns after the rising edge
	task automatic drive_inputs(input int fl, input int fr, input int p);
		@(posedge clk_sys);
		#1;
		fm_left  = fm_sample_t'(fl);
		fm_right = fm_sample_t'(fr);
		psg_in   = psg_sample_t'(p);
	endtask

	// A few cycles of random idle samples between segments
	task automatic drive_filler();
		int cycles;
		cycles = 1 + int'($urandom % 3);
		repeat (cycles) begin
			drive_inputs($urandom, $urandom, $urandom);
		end
	endtask

	// Both enables seen at falling edges, bounded by WAIT_LIMIT
	task automatic wait_enables(input string name);
		int  cycles;
		bit  seen_fm;
		bit  seen_psg;
		cycles   = 0;
		seen_fm  = 1'b0;
		seen_psg = 1'b0;
		while (!(seen_fm && seen_psg) && cycles < WAIT_LIMIT) begin
			@(negedge clk_sys);
			if (fm_ce) begin
				seen_fm = 1'b1;
			end
			if (psg_ce) begin
				seen_psg = 1'b1;
			end
			cycles++;
		end
		if (!(seen_fm && seen_psg)) begin
			$display("TIMEOUT in %s: fm_ce and psg_ce did not both pulse within %0d cycles",
				name, WAIT_LIMIT);
			timeout_count++;
		end
	endtask

	// One segment per trace line
	task automatic run_trace();
		int    fd;
		string line;
		string name;
		int    fl;
		int    fr;
		int    p;
		int    exp_l;
		int    exp_r;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			$display("ERROR: could not open the trace file %s", TRACE_FILE);
			other_count++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			if ($fgets(line, fd) == 0) begin
				break;
			end
			// Comment and blank lines
			if (line.len() == 0 || line[0] == "#") begin
				continue;
			end
			if ($sscanf(line, "%s %d %d %d %d %d", name, fl, fr, p, exp_l, exp_r) != 6) begin
				continue;
			end
			drive_filler();
			drive_inputs(fl, fr, p);
			wait_enables(name);
			// Path register, then mixer register
			repeat (SETTLE_CYCLES) @(negedge clk_sys);
			compare_value({name, " left"}, exp_l, int'(audio_left));
			compare_value({name, " right"}, exp_r, int'(audio_right));
			segment_count++;
		end
		$fclose(fd);
	endtask

	initial begin
		int n;
		rst_n          = 1'b0;
		fm_left        = '0;
		fm_right       = '0;
		psg_in         = '0;
		mismatch_count = 0;
		timeout_count  = 0;
		other_count    = 0;
		segment_count  = 0;
		void'($urandom(32'h590b_37d0));

		// Reset held for 5 rising edges
		for (n = 0; n < RESET_CYCLES; n++) begin
			@(posedge clk_sys);
			#1;
			check_quiet("reset_hold");
		end
		rst_n = 1'b1;

		// Pulse positions counted in falling edges after release
		for (n = 1; n <= ENABLE_WINDOW; n++) begin
			@(negedge clk_sys);
			compare_value("fm_ce_timing", (n % FM_PERIOD == 0) ? 1 : 0, int'(fm_ce));
			compare_value("psg_ce_timing", (n % PSG_PERIOD == 0) ? 1 : 0, int'(psg_ce));
			if (n <= 2) begin
				check_quiet("reset_release");
			end else begin
				compare_value("idle_zero left", 0, int'(audio_left));
				compare_value("idle_zero right", 0, int'(audio_right));
			end
		end

		run_trace();
		if (segment_count == 0) begin
			$display("ERROR: no trace segments were read");
			other_count++;
		end

		$display("Summary: %0d mismatches, %0d timeouts, %0d other errors, %0d segments",
			mismatch_count, timeout_count, other_count, segment_count);
		if (mismatch_count == 0 && timeout_count == 0 && other_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* dv/audio_trace.txt */
# Columns: test name, fm_left, fm_right, psg_in, expected audio_left, expected audio_right
# Signed decimal values, expected outputs are the saturated stereo mix
# FM gain with PSG silent
fm_zero            0       0       0       0       0
fm_one             1      -1       0      22     -23
fm_three           3      -3       0      66     -67
fm_pos_small     100       7       0    2225     155
fm_neg_odd        -5      -7       0    -112    -156
fm_neg_even       -8    -100       0    -178   -2225
fm_odd_mix       333    -333       0    7409   -7410
fm_mid          1000   -1000       0   22250  -22250
fm_edge_pos     1472    1473       0   32752   32767
fm_edge_neg    -1472   -1473       0  -32752  -32768
# PSG with FM silent
psg_one            0       0       1      32      32
psg_31             0       0      31     992     992
psg_32             0       0      32     992     992
psg_100            0       0     100    3104    3104
psg_500            0       0     500   15520   15520
psg_max            0       0    1023   31744   31744
psg_neg_one        0       0      -1       0       0
psg_neg_32         0       0     -32    -992    -992
psg_neg_33         0       0     -33    -992    -992
psg_neg_500        0       0    -500  -15488  -15488
psg_min            0       0   -1024  -31744  -31744
# FM and PSG together, inside the 16-bit range
mix_small        100    -100     100    5329     879
mix_neg_psg        7      -5     -33    -837   -1104
mix_pos_psg      333    -333     500   22929    8110
# Saturation, left and right on different values
sat_fm_full    32767  -32768       0   32767  -32768
sat_fm_swap    -2000    5000       0  -32768   32767
sat_psg_pos     1400   -1400    1023   32767     594
sat_psg_neg    -1400    1400   -1024  -32768    -594
sat_both       32767  -32768    1023   32767   -1024
sat_both_neg  -32768   32767   -1024  -32768    1023
sat_mix_neg     1000   -1000    -500    6762  -32768
sat_edge_pos    1472   -1472       1   32767  -32720
sat_edge_neg   -1472    1472      -2  -32768   32720

/* rtl/audio_mixer.sv */
// Stereo mixer, adds lifted PSG to each FM channel with saturation into a registered 16-bit output
`timescale 1ns/1ps

module audio_mixer
	import audio_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n,
	input  mix_sample_t gained_left,
	input  mix_sample_t gained_right,
	input  psg_sample_t psg_out,
	output mix_sample_t audio_left,
	output mix_sample_t audio_right
);

	// One guard bit is enough for the sum of two 16-bit values
	localparam int SUM_W = MIX_SAMPLE_W + 1;

	localparam logic signed [SUM_W-1:0] SAT_MAX = SUM_W'(32767);
	localparam logic signed [SUM_W-1:0] SAT_MIN = -SUM_W'(32768);

	// Saturating add of one FM channel and the lifted PSG value
	function automatic mix_sample_t sat_add(input mix_sample_t fm, input mix_sample_t psg);
		logic signed [SUM_W-1:0] fm_w;
		logic signed [SUM_W-1:0] psg_w;
		logic signed [SUM_W-1:0] sum;
		fm_w  = {fm[MIX_SAMPLE_W-1], fm};
		psg_w = {psg[MIX_SAMPLE_W-1], psg};
		sum   = fm_w + psg_w;
		// Top two bits differ only on overflow
		if (sum > SAT_MAX) begin
			return mix_sample_t'(SAT_MAX);
		end else if (sum < SAT_MIN) begin
			return mix_sample_t'(SAT_MIN);
		end
		return sum[MIX_SAMPLE_W-1:0];
	endfunction

	// PSG sign-extended to 16 bits
	mix_sample_t psg_ext;
	// PSG scaled into the mix range
	mix_sample_t psg_lift;
	mix_sample_t mix_left;
	mix_sample_t mix_right;

	// Type cast sign extends the 11-bit sample
	assign psg_ext  = mix_sample_t'(psg_out);
	// Upper bits of the extension are pure sign, so the shift is exact
	assign psg_lift = psg_ext <<< PSG_LIFT_SHIFT;

	// Same mono voice goes to both sides
	assign mix_left  = sat_add(gained_left, psg_lift);
	assign mix_right = sat_add(gained_right, psg_lift);

	// Output register, loads every clock
	// One cycle behind any change on the path outputs
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			audio_left  <= '0;
			audio_right <= '0;
		end else begin
			audio_left  <= mix_left;
			audio_right <= mix_right;
		end
	end

endmodule

/* rtl/audio_pkg.sv */
// Audio back end shared types, sample widths, clock-enable periods and PSG shift amounts
package audio_pkg;

	// Sample widths as delivered by the sound engines
	localparam int FM_SAMPLE_W  = 16;
	localparam int PSG_SAMPLE_W = 11;
	// Mixer domain matches the 16-bit DAC word
	localparam int MIX_SAMPLE_W = 16;

	// One stereo FM channel sample, signed
	typedef logic signed [FM_SAMPLE_W-1:0]  fm_sample_t;
	// Mono PSG sample, signed
	typedef logic signed [PSG_SAMPLE_W-1:0] psg_sample_t;
	// Final mixed output sample, signed
	typedef logic signed [MIX_SAMPLE_W-1:0] mix_sample_t;

	// FM chip enable period in system clocks
	localparam int FM_CE_DIVIDE  = 7;
	// PSG chip enable period in system clocks
	localparam int PSG_CE_DIVIDE = 15;

	// PSG attenuation subtracts sample >>> 5
	// i.e. gain of 31/32
	localparam int PSG_ATTEN_SHIFT = 5;

	// Lifts the 11-bit PSG value into the 16-bit mix range
	// 11 + 5 = 16, so the lift never overflows
	localparam int PSG_LIFT_SHIFT = 5;

endpackage

/* rtl/audio_top.sv */
// Audio back end top, paces the FM and PSG engines and mixes their samples to stereo
`timescale 1ns/1ps

module audio_top
	import audio_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n,
	// FM engine stereo samples, held levels
	input  fm_sample_t  fm_left,
	input  fm_sample_t  fm_right,
	// PSG engine mono sample, held level
	input  psg_sample_t psg_in,
	// Chip enables back to the engines
	output logic        fm_ce,
	output logic        psg_ce,
	// Mixed stereo out, continuous levels
	output mix_sample_t audio_left,
	output mix_sample_t audio_right
);

	// FM path results after gain
	mix_sample_t gained_left;
	mix_sample_t gained_right;
	// PSG path result after attenuation
	psg_sample_t psg_out;

	// FM pacing, every 7 clocks
	ce_divider #(
		.DIVIDE(FM_CE_DIVIDE)
	) fm_ce_div (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.ce      (fm_ce)
	);

	// PSG pacing, every 15 clocks
	ce_divider #(
		.DIVIDE(PSG_CE_DIVIDE)
	) psg_ce_div (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.ce      (psg_ce)
	);

	// Stereo FM capture and 22.25 gain
	fm_path fm_path0 (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.fm_ce        (fm_ce),
		.fm_left      (fm_left),
		.fm_right     (fm_right),
		.gained_left  (gained_left),
		.gained_right (gained_right)
	);

	// Mono PSG capture and 31/32 attenuation
	psg_path psg_path0 (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.psg_ce  (psg_ce),
		.psg_in  (psg_in),
		.psg_out (psg_out)
	);

	// Sum and clamp, enable to output is 2 cycles overall
	audio_mixer mixer0 (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.gained_left  (gained_left),
		.gained_right (gained_right),
		.psg_out      (psg_out),
		.audio_left   (audio_left),
		.audio_right  (audio_right)
	);

endmodule

/* rtl/ce_divider.sv */
// Clock-enable divider giving a registered one-cycle pulse every DIVIDE system clocks
`timescale 1ns/1ps

module ce_divider #(
	// Period in system clocks, 2 to 16 with the 4-bit counter
	parameter int DIVIDE = 7
) (
	input  logic clk_sys,
	input  logic rst_n,
	output logic ce
);

	// Count value on which the pulse is high
	localparam logic [3:0] LAST = 4'(DIVIDE - 1);
	// One count earlier, so the registered pulse lines up with LAST
	localparam logic [3:0] PRE  = 4'(DIVIDE - 2);

	logic [3:0] count;

	// Free-running counter, wraps after LAST
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			count <= '0;
		end else if (count == LAST) begin
			count <= '0;
		end else begin
			count <= count + 4'd1;
		end
	end

	// Pulse register
	// Set on PRE so ce is high exactly while count sits at LAST
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ce <= 1'b0;
		end else begin
			ce <= (count == PRE);
		end
	end

endmodule

/* rtl/fm_path.sv */
// FM sample path, captures stereo samples on the FM enable and applies saturating 22.25 gain
`timescale 1ns/1ps

module fm_path
	import audio_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        fm_ce,
	input  fm_sample_t  fm_left,
	input  fm_sample_t  fm_right,
	output mix_sample_t gained_left,
	output mix_sample_t gained_right
);

	// Gain terms: x*16 + x*4 + x*2 + x/4 = 22.25x
	localparam int GAIN_SHL_HI  = 4;
	localparam int GAIN_SHL_MID = 2;
	localparam int GAIN_SHL_LO  = 1;
	localparam int GAIN_SHR     = 2;

	// 16-bit input times 22.25 needs 21 bits signed
	localparam int GAIN_W = FM_SAMPLE_W + 5;

	// Clamp limits expressed in the widened width
	localparam logic signed [GAIN_W-1:0] SAT_MAX = GAIN_W'(32767);
	localparam logic signed [GAIN_W-1:0] SAT_MIN = -GAIN_W'(32768);

	// Gain and clamp for one channel
	function automatic mix_sample_t apply_gain(input fm_sample_t x);
		logic signed [GAIN_W-1:0] wide;
		logic signed [GAIN_W-1:0] sum;
		// Sign extend before shifting so no bits are lost
		wide = {{(GAIN_W - FM_SAMPLE_W){x[FM_SAMPLE_W-1]}}, x};
		// Quarter term rounds toward minus infinity
		sum = (wide <<< GAIN_SHL_HI) + (wide <<< GAIN_SHL_MID)
			+ (wide <<< GAIN_SHL_LO) + (wide >>> GAIN_SHR);
		if (sum > SAT_MAX) begin
			return mix_sample_t'(SAT_MAX);
		end else if (sum < SAT_MIN) begin
			return mix_sample_t'(SAT_MIN);
		end
		// In range, low bits carry the value and the sign
		return sum[MIX_SAMPLE_W-1:0];
	endfunction

	mix_sample_t next_left;
	mix_sample_t next_right;

	// Both channels gained in parallel
	assign next_left  = apply_gain(fm_left);
	assign next_right = apply_gain(fm_right);

	// Sample and hold on the FM enable
	// Output changes one cycle after the enable edge
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			gained_left  <= '0;
			gained_right <= '0;
		end else if (fm_ce) begin
			gained_left  <= next_left;
			gained_right <= next_right;
		end
	end

endmodule

/* rtl/psg_path.sv */
// PSG sample path, captures the mono sample on the PSG enable and applies 31/32 attenuation
`timescale 1ns/1ps

module psg_path
	import audio_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        psg_ce,
	input  psg_sample_t psg_in,
	output psg_sample_t psg_out
);

	// Attenuation term, arithmetic shift keeps the sign
	psg_sample_t atten_part;
	// Sample after attenuation
	psg_sample_t atten_val;

	assign atten_part = psg_in >>> PSG_ATTEN_SHIFT;

	// Magnitude only shrinks here
	// Negative values floor, so -1 becomes 0 and -1024 becomes -992
	assign atten_val = psg_in - atten_part;

	// Hold register, updated only on the PSG enable
	// FM side keeps moving at its own rate while this stays put
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			psg_out <= '0;
		end else if (psg_ce) begin
			psg_out <= atten_val;
		end
	end

endmodule

/* tb.f */
rtl/audio_pkg.sv
rtl/ce_divider.sv
rtl/fm_path.sv
rtl/psg_path.sv
rtl/audio_mixer.sv
rtl/audio_top.sv
dv/audio_asserts.sv
dv/audio_tb.sv
